// File: hw/radar_pkg.sv
// radar pulse digitizer shared types
// widths, source and mode encodings, and the structs that carry
// configuration, selected signals, samples and pulse counts
`default_nettype none

package radar_pkg;

   localparam int adc_w    = 12;   // adc sample width
   localparam int sample_w = 16;   // output word width
   localparam int count_w  = 32;   // pulse counts, sample counts, latencies

   typedef logic [adc_w-1:0] adc_t;

   // which adc channel feeds a radar signal
   typedef enum logic [1:0] {
      rx_a_a = 2'd0,
      rx_b_a = 2'd1,
      rx_a_b = 2'd2,
      rx_b_b = 2'd3
   } src_sel_t;

   typedef enum logic [2:0] {
      mode_pulse_video = 3'd0,   // runs start on trigger
      mode_raw_video   = 3'd1,
      mode_raw_trig    = 3'd2,
      mode_raw_arp     = 3'd3,
      mode_raw_acp     = 3'd4,
      mode_interleave  = 3'd5    // video, trig, arp, acp in turn
   } radar_mode_t;

   // one detector's thresholds and re-arm holdoff
   typedef struct packed {
      adc_t               excite;
      adc_t               relax;
      logic [count_w-1:0] latency;
   } det_cfg_t;

   typedef struct packed {
      logic               enable;       // host wants capture
      radar_mode_t        mode;
      logic               vid_negate;   // mode 0 only
      logic [15:0]        decim_rate;
      logic [count_w-1:0] n_samples;    // samples per run
      src_sel_t           vid_src;
      src_sel_t           trig_src;
      src_sel_t           arp_src;
      src_sel_t           acp_src;
      det_cfg_t           trig;
      det_cfg_t           arp;
      det_cfg_t           acp;
   } radar_cfg_t;

   typedef struct packed {
      adc_t video;
      adc_t trig;
      adc_t arp;
      adc_t acp;
   } radar_signals_t;

   // zero-extended channel value
   typedef struct packed {
      logic [sample_w-adc_w-1:0] pad;
      adc_t                      value;
   } sample_t;

   typedef struct packed {
      logic [count_w-1:0] n_trigs;
      logic [count_w-1:0] n_arps;
      logic [count_w-1:0] n_acps;
   } pulse_stats_t;

endpackage

`default_nettype wire

// File: hw/source_select.sv
// signal source selector
// routes the four adc channels onto video, trigger, arp and acp
`default_nettype none

module source_select
(
   input  wire radar_pkg::adc_t         rx_a_a,
   input  wire radar_pkg::adc_t         rx_b_a,
   input  wire radar_pkg::adc_t         rx_a_b,
   input  wire radar_pkg::adc_t         rx_b_b,
   input  wire radar_pkg::radar_cfg_t   cfg,
   output radar_pkg::radar_signals_t    signals
);
   import radar_pkg::*;

   // one 4:1 mux, channels passed in so the assigns see every input
   function automatic adc_t route(input src_sel_t sel, input adc_t a_a, input adc_t b_a,
                                  input adc_t a_b, input adc_t b_b);
      case (sel)
         radar_pkg::rx_a_a: route = a_a;
         radar_pkg::rx_b_a: route = b_a;
         radar_pkg::rx_a_b: route = a_b;
         default:           route = b_b;
      endcase
   endfunction

   assign signals.video = route(cfg.vid_src,  rx_a_a, rx_b_a, rx_a_b, rx_b_b);
   assign signals.trig  = route(cfg.trig_src, rx_a_a, rx_b_a, rx_a_b, rx_b_b);
   assign signals.arp   = route(cfg.arp_src,  rx_a_a, rx_b_a, rx_a_b, rx_b_b);
   assign signals.acp   = route(cfg.acp_src,  rx_a_a, rx_b_a, rx_a_b, rx_b_b);

endmodule

`default_nettype wire

// File: hw/pulse_detector.sv
// pulse detector with hysteresis
// fires once when an armed input reaches excite, re-arms after the
// input drops below relax and the holdoff latency has run out
`default_nettype none

module pulse_detector
(
   input  wire logic                       clk64,
   input  wire logic                       rx_dsp_reset,
   input  wire logic                       enable_rx,
   input  wire radar_pkg::adc_t            level,
   input  wire radar_pkg::det_cfg_t        det_cfg,
   output logic                            pulse,
   output logic [radar_pkg::count_w-1:0]   count
);
   import radar_pkg::*;

   logic               armed;     // ready to fire on next excursion
   logic [count_w-1:0] holdoff;   // cycles left before re-arm allowed
   logic               fire;

   assign fire = enable_rx & armed & (level >= det_cfg.excite);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         armed   <= 1'b0;
         holdoff <= '0;
         pulse   <= 1'b0;
         count   <= '0;
      end
      else
      begin
         pulse <= fire;                        // strobe one cycle after the crossing
         if (!enable_rx)
         begin
            // idle, must see a dip below relax before the first pulse
            armed   <= 1'b0;
            holdoff <= '0;
         end
         else if (fire)
         begin
            armed   <= 1'b0;
            holdoff <= det_cfg.latency;
            count   <= count + 1'b1;
         end
         else
         begin
            if (holdoff != '0)
               holdoff <= holdoff - 1'b1;
            // hovering between relax and excite leaves us disarmed
            if (!armed && holdoff == '0 && level < det_cfg.relax)
               armed <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/capture_ctrl.sv
// capture control
// waits out the settle delay, starts and stops sample runs,
// counts samples per run and tracks stream credits and overrun
`default_nettype none

module capture_ctrl
#(
   parameter int settle_cycles = 6_400_000,
   parameter int max_credits   = 8
)
(
   input  wire logic                  clk64,
   input  wire logic                  rx_dsp_reset,
   input  wire radar_pkg::radar_cfg_t cfg,
   input  wire logic                  trig_pulse,
   input  wire logic                  mux_strobe,
   input  wire logic                  credit_return,
   output logic                       enable_rx,
   output logic                       run_start,
   output logic                       run_active,
   output logic                       sample_valid,
   output logic                       overrun
);
   import radar_pkg::*;

   localparam int settle_w = $clog2(settle_cycles + 1);
   localparam int credit_w = $clog2(max_credits + 1);
   localparam logic [settle_w-1:0] settle_last = settle_w'(settle_cycles - 1);
   localparam logic [credit_w-1:0] credit_max  = credit_w'(max_credits);

   logic [settle_w-1:0] settle_cnt;   // consecutive cycles with cfg.enable high
   logic [count_w-1:0]  run_cnt;      // samples due so far in this run
   logic [credit_w-1:0] credits;
   logic                continuous;
   logic                start_cond;
   logic                no_credit;
   logic                last_sample;

   assign continuous   = (cfg.mode != mode_pulse_video);
   assign start_cond   = enable_rx & ~run_active & (continuous | trig_pulse);
   assign no_credit    = (credits == '0);
   assign last_sample  = (run_cnt + 1'b1 >= cfg.n_samples);   // dropped ones count too
   assign sample_valid = mux_strobe & run_active & ~no_credit;

   // settle delay before capture is allowed
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !cfg.enable)
      begin
         settle_cnt <= '0;
         enable_rx  <= 1'b0;
      end
      else if (settle_cnt == settle_last)
         enable_rx <= 1'b1;                  // hold count here once settled
      else
         settle_cnt <= settle_cnt + 1'b1;
   end

   // run start / stop and per-run sample count
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         run_start  <= 1'b0;
         run_active <= 1'b0;
         run_cnt    <= '0;
      end
      else
      begin
         run_start <= start_cond;
         if (start_cond)
         begin
            run_active <= 1'b1;
            run_cnt    <= '0;
         end
         else if (!enable_rx)
            run_active <= 1'b0;              // host pulled enable mid-run
         else if (mux_strobe && run_active)
         begin
            run_cnt <= run_cnt + 1'b1;
            if (last_sample)
               run_active <= 1'b0;
         end
      end
   end

   // credits: send takes one, return gives one back, both at once is a wash
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         credits <= credit_max;
         overrun <= 1'b0;
      end
      else
      begin
         if (sample_valid && !credit_return)
            credits <= credits - 1'b1;
         else if (!sample_valid && credit_return && credits != credit_max)
            credits <= credits + 1'b1;
         if (mux_strobe && run_active && no_credit)
            overrun <= 1'b1;                 // sticky until reset
      end
   end

endmodule

`default_nettype wire

// File: hw/sample_decim.sv
// decimation strobe generator
// strobes every decim_rate cycles during a run, phase set by run_start
`default_nettype none

module sample_decim
(
   input  wire logic        clk64,
   input  wire logic        rx_dsp_reset,
   input  wire logic        run_start,
   input  wire logic        run_active,
   input  wire logic [15:0] decim_rate,
   output logic             decim_strobe
);

   logic [15:0] cnt;      // cycles left until next strobe
   logic [15:0] reload;

   // rate 0 behaves as rate 1
   assign reload       = (decim_rate == 16'd0) ? 16'd0 : decim_rate - 16'd1;
   assign decim_strobe = run_active & ~run_start & (cnt == 16'd0);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         cnt <= '0;
      else if (run_start || decim_strobe)
         cnt <= reload;                     // restart period
      else if (run_active && cnt != 16'd0)
         cnt <= cnt - 16'd1;
   end

endmodule

`default_nettype wire

// File: hw/sample_mux.sv
// sample multiplexer
// picks the output value by capture mode, negates video when asked,
// steps the interleave phase, and registers the sample word
`default_nettype none

module sample_mux
(
   input  wire logic                      clk64,
   input  wire logic                      rx_dsp_reset,
   input  wire radar_pkg::radar_signals_t signals,
   input  wire radar_pkg::radar_mode_t    mode,
   input  wire logic                      vid_negate,
   input  wire logic                      run_start,
   input  wire logic                      decim_strobe,
   output radar_pkg::sample_t             sample,
   output logic                           mux_strobe
);
   import radar_pkg::*;

   logic [1:0] phase;   // interleave slot: 0 video, 1 trig, 2 arp, 3 acp
   adc_t       pick;

   always_comb
   begin
      case (mode)
         mode_pulse_video: pick = vid_negate ? adc_t'(12'hfff) - signals.video : signals.video;
         mode_raw_video:   pick = signals.video;
         mode_raw_trig:    pick = signals.trig;
         mode_raw_arp:     pick = signals.arp;
         mode_raw_acp:     pick = signals.acp;
         mode_interleave:
            case (phase)
               2'd0:    pick = signals.video;
               2'd1:    pick = signals.trig;
               2'd2:    pick = signals.arp;
               default: pick = signals.acp;
            endcase
         default:          pick = signals.video;   // unused codes
      endcase
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         phase      <= 2'd0;
         mux_strobe <= 1'b0;
      end
      else
      begin
         mux_strobe <= decim_strobe;
         if (run_start)
            phase <= 2'd0;              // each run opens on video
         else if (decim_strobe)
            phase <= phase + 2'd1;
      end
   end

   // payload, only loaded on a decimated tick
   always_ff @(posedge clk64)
   begin
      if (decim_strobe)
      begin
         sample.pad   <= '0;
         sample.value <= pick;
      end
   end

endmodule

`default_nettype wire

// File: hw/radar_digitizer.sv
// marine radar baseband pulse digitizer, top level
// selects video/trigger/heading/azimuth from four adc channels,
// counts pulses and streams decimated samples under credit flow control
`default_nettype none

module radar_digitizer
#(
   parameter int settle_cycles = 6_400_000,   // 0.1 s at 64 MHz
   parameter int max_credits   = 8
)
(
   input  wire logic                    clk64,
   input  wire logic                    rx_dsp_reset,
   input  wire radar_pkg::adc_t         rx_a_a,
   input  wire radar_pkg::adc_t         rx_b_a,
   input  wire radar_pkg::adc_t         rx_a_b,
   input  wire radar_pkg::adc_t         rx_b_b,
   input  wire radar_pkg::radar_cfg_t   cfg,
   input  wire logic                    credit_return,
   output radar_pkg::sample_t           sample,
   output logic                         sample_valid,
   output logic                         overrun,
   output radar_pkg::pulse_stats_t      stats
);
   import radar_pkg::*;

   radar_signals_t signals;      // selected video, trig, arp, acp
   logic           enable_rx;    // capture enabled after settle
   logic           trig_pulse;
   logic           run_start;
   logic           run_active;
   logic           decim_strobe;
   logic           mux_strobe;

   source_select src_i
   (
      .rx_a_a (rx_a_a), .rx_b_a (rx_b_a), .rx_a_b (rx_a_b), .rx_b_b (rx_b_b),
      .cfg    (cfg),
      .signals(signals)
   );

   pulse_detector trig_det
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .enable_rx(enable_rx),
      .level(signals.trig), .det_cfg(cfg.trig),
      .pulse(trig_pulse), .count(stats.n_trigs)
   );

   // arp and acp are only counted, their strobes go nowhere
   pulse_detector arp_det
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .enable_rx(enable_rx),
      .level(signals.arp), .det_cfg(cfg.arp),
      .pulse(), .count(stats.n_arps)
   );

   pulse_detector acp_det
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .enable_rx(enable_rx),
      .level(signals.acp), .det_cfg(cfg.acp),
      .pulse(), .count(stats.n_acps)
   );

   capture_ctrl #(.settle_cycles(settle_cycles), .max_credits(max_credits)) ctrl_i
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .cfg(cfg),
      .trig_pulse(trig_pulse), .mux_strobe(mux_strobe), .credit_return(credit_return),
      .enable_rx(enable_rx), .run_start(run_start), .run_active(run_active),
      .sample_valid(sample_valid), .overrun(overrun)
   );

   sample_decim decim_i
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
      .run_start(run_start), .run_active(run_active),
      .decim_rate(cfg.decim_rate), .decim_strobe(decim_strobe)
   );

   sample_mux mux_i
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .signals(signals),
      .mode(cfg.mode), .vid_negate(cfg.vid_negate),
      .run_start(run_start), .decim_strobe(decim_strobe),
      .sample(sample), .mux_strobe(mux_strobe)
   );

endmodule

`default_nettype wire

// File: dv/radar_tb.sv
// radar digitizer testbench
// replays trace records: config, channel levels, pulse and credit schedule,
// checks every streamed sample, sample counts, overrun and pulse stats
`default_nettype none

module radar_tb;
   import radar_pkg::*;

   localparam int settle         = 16;     // settle_cycles given to the DUT
   localparam int timeout_cycles = 5000;
   localparam int excite_lvl     = 2000;
   localparam int relax_lvl      = 1000;
   localparam int high_lvl       = 3000;   // pulse peak

   logic         clk64 = 1'b0;
   logic         rx_dsp_reset;
   adc_t         chan [0:3];               // rx_a_a, rx_b_a, rx_a_b, rx_b_b
   radar_cfg_t   cfg;
   logic         credit_return = 1'b0;
   sample_t      sample;
   logic         sample_valid;
   logic         overrun;
   pulse_stats_t stats;

   // current trace record
   logic [8*24-1:0] test_name;
   int mode, neg, decim, nsamp, npulse, hover, gap, bounce, credit_on, nexp, ovr;
   int src [0:3];      // video, trig, arp, acp selectors
   int lvl [0:3];      // static channel levels
   int lat [0:2];      // trig, arp, acp holdoff
   int n_exp [0:2];    // expected trig, arp, acp counts
   int seen = 0;       // samples streamed in this test
   int en_cnt = 0;     // cycles with cfg.enable high
   int n_tests = 0;

   always #10 clk64 = ~clk64;

   radar_digitizer #(.settle_cycles(settle), .max_credits(8)) dut_i
   (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
      .rx_a_a(chan[0]), .rx_b_a(chan[1]), .rx_a_b(chan[2]), .rx_b_b(chan[3]),
      .cfg(cfg), .credit_return(credit_return),
      .sample(sample), .sample_valid(sample_valid), .overrun(overrun), .stats(stats)
   );

   task automatic fail_now();
      $display("TESTS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_sample(input string what, input sample_t exp, input sample_t act);
      if (exp !== act)
      begin
         $display("[FAIL] %0s %0s: expected 16'h%h, actual 16'h%h", test_name, what, exp, act);
         fail_now();
      end
   endtask

   task automatic check_stats(input pulse_stats_t exp, input pulse_stats_t act);
      if (exp !== act)
      begin
         $display("[FAIL] %0s stats: expected %0d/%0d/%0d, actual %0d/%0d/%0d", test_name,
                  exp.n_trigs, exp.n_arps, exp.n_acps, act.n_trigs, act.n_arps, act.n_acps);
         fail_now();
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("[FAIL] %0s %0s: expected %b, actual %b", test_name, what, exp, act);
         fail_now();
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      if (exp != act)
      begin
         $display("[FAIL] %0s %0s: expected %0d, actual %0d", test_name, what, exp, act);
         fail_now();
      end
   endtask

   // value the stream should carry for the idx-th sample of this test
   function automatic sample_t expected_sample(input int idx);
      sample_t s;
      int      ph;
      ph = (idx % nsamp) % 4;                       // runs restart on video
      s.pad = '0;
      case (mode)
         0:          s.value = neg != 0 ? adc_t'(4095 - lvl[src[0]]) : adc_t'(lvl[src[0]]);
         1, 2, 3, 4: s.value = adc_t'(lvl[src[mode-1]]);
         default:    s.value = adc_t'(lvl[src[ph]]);
      endcase
      return s;
   endfunction

   function automatic det_cfg_t det_config(input int latency);
      det_cfg_t d;
      d.excite  = adc_t'(excite_lvl);
      d.relax   = adc_t'(relax_lvl);
      d.latency = latency;
      return d;
   endfunction

   // kind 0 base level, 1 peak, 2 noisy plateau inside the hysteresis band
   task automatic hold_level(input int kind, input int cycles);
      int ch;
      repeat (cycles)
      begin
         @(posedge clk64);
         for (int i = 1; i < 4; i++)
         begin
            ch = src[i];
            case (kind)
               0:       chan[ch] <= adc_t'(lvl[ch]);
               1:       chan[ch] <= adc_t'(high_lvl);
               default: chan[ch] <= adc_t'(relax_lvl + 100 + $urandom % 800);
            endcase
         end
      end
   endtask

   task automatic drive_pulses();
      for (int k = 0; k < npulse; k++)
      begin
         hold_level(1, 2);
         hold_level(2, hover);
         if (bounce != 0)
         begin
            hold_level(1, 2);      // second peak without a dip, counts once
            hold_level(2, hover);
         end
         hold_level(0, gap);
      end
   endtask

   task automatic wait_samples(input int n);
      for (int t = 0; t < timeout_cycles && seen < n; t++)
         @(posedge clk64);
      if (seen < n)
      begin
         $display("%0s: timed out waiting for %0d samples, only %0d came", test_name, n, seen);
         fail_now();
      end
   endtask

   task automatic wait_overrun();
      for (int t = 0; t < timeout_cycles && overrun !== 1'b1; t++)
         @(posedge clk64);
      if (overrun !== 1'b1)
      begin
         $display("%0s: timed out waiting for the overrun flag to set", test_name);
         fail_now();
      end
   endtask

   task automatic run_test();
      radar_cfg_t   c;
      pulse_stats_t es;
      n_tests++;
      c            = '0;
      c.mode       = radar_mode_t'(mode);
      c.vid_negate = (neg != 0);
      c.decim_rate = 16'(decim);
      c.n_samples  = nsamp;
      c.vid_src    = src_sel_t'(src[0]);
      c.trig_src   = src_sel_t'(src[1]);
      c.arp_src    = src_sel_t'(src[2]);
      c.acp_src    = src_sel_t'(src[3]);
      c.trig       = det_config(lat[0]);
      c.arp        = det_config(lat[1]);
      c.acp        = det_config(lat[2]);
      @(posedge clk64);
      rx_dsp_reset <= 1'b1;
      cfg          <= c;
      for (int i = 0; i < 4; i++)
         chan[i] <= adc_t'(lvl[i]);
      repeat (4) @(posedge clk64);
      rx_dsp_reset <= 1'b0;
      @(posedge clk64);
      c.enable = 1'b1;
      cfg <= c;
      repeat (settle + 10) @(posedge clk64);     // settle, then detectors arm
      drive_pulses();
      if (credit_on == 0)
         wait_overrun();
      else
         wait_samples(nexp);
      if (mode == 0 || credit_on == 0)
      begin
         repeat (decim * nsamp + 40) @(posedge clk64);   // room for stray samples
         check_count("sample count", nexp, seen);
      end
      check_flag("overrun", ovr != 0, overrun);
      es.n_trigs = n_exp[0];
      es.n_arps  = n_exp[1];
      es.n_acps  = n_exp[2];
      check_stats(es, stats);
      c.enable = 1'b0;
      cfg          <= c;
      rx_dsp_reset <= 1'b1;                      // stream stays quiet while the next record loads
      @(posedge clk64);
   endtask

   // stream monitor, returns one credit per sample when enabled
   always @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         seen          <= 0;
         en_cnt        <= 0;
         credit_return <= 1'b0;
      end
      else
      begin
         en_cnt        <= cfg.enable ? en_cnt + 1 : 0;
         credit_return <= sample_valid && credit_on != 0;
         if (sample_valid)
         begin
            if (en_cnt < settle)
               check_flag("sample before settle", 1'b0, sample_valid);
            check_sample("sample", expected_sample(seen), sample);
            seen <= seen + 1;
         end
      end
   end

   initial
   begin
      int                fd;
      int                nf;
      int                rc;
      logic [8*160-1:0]  line;
      void'($urandom(32'h9927_7f40));
      rx_dsp_reset = 1'b1;
      cfg          = '0;
      credit_on    = 1;
      for (int i = 0; i < 4; i++)
         chan[i] = '0;
      fd = $fopen("dv/radar_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file dv/radar_trace.txt");
         fail_now();
      end
      while (!$feof(fd))
      begin
         line = '0;
         rc   = $fgets(line, fd);
         nf   = $sscanf(line,
            "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
            test_name, mode, neg, decim, nsamp, src[0], src[1], src[2], src[3],
            lvl[0], lvl[1], lvl[2], lvl[3], npulse, hover, gap, bounce,
            lat[0], lat[1], lat[2], credit_on, nexp, n_exp[0], n_exp[1], n_exp[2], ovr);
         if (rc > 0 && nf == 26)                 // comment and blank lines fall out here
            run_test();
      end
      $fclose(fd);
      if (n_tests > 0)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("the trace file holds no test records");
         fail_now();
      end
   end

endmodule

`default_nettype wire

// File: all.f
hw/radar_pkg.sv
hw/source_select.sv
hw/pulse_detector.sv
hw/capture_ctrl.sv
hw/sample_decim.sv
hw/sample_mux.sv
hw/radar_digitizer.sv
dv/radar_tb.sv

// File: dv/radar_trace.txt
# name mode neg decim nsamp vsrc tsrc asrc csrc lvl_a_a lvl_b_a lvl_a_b lvl_b_b npulse hover gap
# bounce lat_t lat_a lat_c credit nexp exp_trigs exp_arps exp_acps exp_overrun
settle_gate       0 0 3   5 1 0 2 3  200 1234  300  400 0 4 40 0  8  8  8 1  0 0 0 0 0
pulse_video       0 0 3   5 1 0 2 3  200 1234  300  400 3 4 40 0  8  8  8 1 15 3 3 3 0
pulse_video_b     0 0 2   3 0 1 2 3 2750  150  250  350 2 5 30 1  8  8  8 1  6 2 2 2 0
pulse_negate      0 1 4   8 3 2 1 0  150  250  350 1000 4 4 10 0  8 20  8 1 16 4 2 4 0
raw_video         1 0 2   6 3 0 1 2  111  222  333 3333 0 4 10 0  8  8  8 1 12 0 0 0 0
raw_trig          2 0 2   5 0 2 3 1 2500 1500 2900  700 0 4 10 0  8  8  8 1 10 0 0 0 0
raw_arp           3 0 3   4 1 3 0 2  640 3900 1777   80 0 4 10 0  8  8  8 1  8 0 0 0 0
raw_acp           4 0 2   7 2 0 3 1    5 4095 2048  999 0 4 10 0  8  8  8 1 14 0 0 0 0
interleave        5 0 3   6 0 1 2 3 1111 2222 3333  444 0 4 10 0  8  8  8 1 18 0 0 0 0
interleave_remap  5 0 2   4 3 2 1 0   10   20   30   40 0 4 10 0  8  8  8 1 12 0 0 0 0
credit_stall      1 0 2 100 2 0 1 3  100  200 3000  400 0 4 10 0  8  8  8 0  8 0 0 0 1
credit_stall_ilv  5 0 3  20 0 1 2 3  900 1800 2700 3600 0 4 10 0  8  8  8 0  8 0 0 0 1
credit_flow       5 0 2   9 3 0 1 2   77  555 1555 2555 0 4 10 0  8  8  8 1 40 0 0 0 0
credit_flow_raw   4 0 2   3 0 1 2 3   10   20   30 4000 0 4 10 0  8  8  8 1 30 0 0 0 0
pulse_count       1 0 4  10 3 0 2 1  300  200  100 1500 5 6 30 1  4 50 10 1 10 5 3 5 0
